/* files.f */
hw/gat_pkg.sv
hw/spmm_engine.sv
hw/attn_score_unit.sv
hw/softmax_weight_unit.sv
hw/aggregator.sv
hw/debugger.sv
hw/gat_layer_top.sv
test/gat_layer_tb.sv

/* hw/aggregator.sv */
`timescale 1ns/1ps
`default_nettype none

module aggregator (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wgt_vld_i,
  input  logic        [gat_pkg::ATTN_WGT_W-1:0] attn_wgt_i,
  input  logic signed [gat_pkg::WH_W-1:0]       wh_i,
  input  logic                                  grp_last_i,
  input  logic        [gat_pkg::FEAT_ADDR_W-1:0] feat_base_i,
  output logic                                  aggr_vld_o,
  output logic                                  aggr_rdy_o,
  output logic                                  feat_bram_ena_o,
  output logic        [gat_pkg::FEAT_ADDR_W-1:0] feat_bram_addra_o,
  output logic        [gat_pkg::FEAT_W-1:0]     feat_bram_din_o
);

  logic signed [gat_pkg::ACC_W-1:0]      wprod;
  logic signed [gat_pkg::ACC_W-1:0]      acc_q;
  logic        [gat_pkg::ACC_W-1:0]      acc_abs;
  logic        [gat_pkg::DEN_W-1:0]      den_q;
  logic        [gat_pkg::FEAT_ADDR_W-1:0] grp_cnt_q;
  logic                                  load_q;
  logic                                  div_q;
  logic [$clog2(gat_pkg::FEAT_W)-1:0]    cnt_q;

  logic [gat_pkg::DEN_W-1:0]  rem_q;
  logic [gat_pkg::FEAT_W-1:0] dq_q;  // Dividend bits shift out, quotient bits shift in.
  logic                       neg_q;
  logic [gat_pkg::DEN_W:0]    trial;
  logic [gat_pkg::DEN_W:0]    diff;
  logic                       ge;
  logic [gat_pkg::DEN_W-1:0]  rem_next;
  logic [gat_pkg::FEAT_W-1:0] dq_next;

  assign wprod   = $signed({1'b0, attn_wgt_i}) * wh_i;
  assign acc_abs = acc_q[gat_pkg::ACC_W-1] ? -acc_q : acc_q;

  // One restoring step. The remainder stays below the divisor throughout.
  assign trial    = {rem_q, dq_q[gat_pkg::FEAT_W-1]};
  assign diff     = trial - {1'b0, den_q};
  assign ge       = (trial >= {1'b0, den_q});
  assign rem_next = ge ? diff[gat_pkg::DEN_W-1:0] : trial[gat_pkg::DEN_W-1:0];
  assign dq_next  = {dq_q[gat_pkg::FEAT_W-2:0], ge};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q      <= '0;
      den_q      <= '0;
      grp_cnt_q  <= '0;
      load_q     <= 1'b0;
      div_q      <= 1'b0;
      cnt_q      <= '0;
      aggr_vld_o <= 1'b0;
    end else begin
      aggr_vld_o <= 1'b0;
      load_q     <= 1'b0;
      if (wgt_vld_i) begin
        acc_q  <= acc_q + wprod;
        den_q  <= den_q + {{(gat_pkg::DEN_W - gat_pkg::ATTN_WGT_W){1'b0}}, attn_wgt_i};
        load_q <= grp_last_i; // Group end starts the divide.
      end
      if (load_q) begin
        div_q <= 1'b1;
        cnt_q <= '0;
      end
      if (div_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (&cnt_q) begin
          div_q      <= 1'b0;
          aggr_vld_o <= 1'b1;
          acc_q      <= '0;
          den_q      <= '0;
          grp_cnt_q  <= grp_cnt_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_q) begin
      // The quotient magnitude fits in FEAT_W bits, so the top bits fit in the remainder.
      rem_q <= {{(gat_pkg::DEN_W - gat_pkg::DIV_HI_W){1'b0}},
                acc_abs[gat_pkg::ACC_W-1:gat_pkg::FEAT_W]};
      dq_q  <= acc_abs[gat_pkg::FEAT_W-1:0];
      neg_q <= acc_q[gat_pkg::ACC_W-1];
    end else if (div_q) begin
      rem_q <= rem_next;
      dq_q  <= dq_next;
      if (&cnt_q) begin
        feat_bram_din_o   <= neg_q ? -dq_next : dq_next; // Truncates toward zero.
        feat_bram_addra_o <= feat_base_i + grp_cnt_q;
      end
    end
  end

  assign aggr_rdy_o      = ~(load_q | div_q);
  assign feat_bram_ena_o = aggr_vld_o;

endmodule

`default_nettype wire

/* hw/attn_score_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module attn_score_unit (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               wh_vld_i,
  input  logic signed [gat_pkg::WH_W-1:0]    wh_i,
  input  logic                               grp_last_i,
  input  logic signed [gat_pkg::WGT_W-1:0]   attn_coef_i,
  input  logic        [gat_pkg::SHIFT_W-1:0] attn_shift_i,
  output logic                               score_vld_o,
  output logic                               score_rdy_o,
  output logic signed [gat_pkg::SCORE_W-1:0] score_o,
  output logic signed [gat_pkg::WH_W-1:0]    wh_o,
  output logic                               grp_last_o
);

  logic signed [gat_pkg::SCORE_W-1:0] scaled;
  logic signed [gat_pkg::SCORE_W-1:0] shifted;
  logic signed [gat_pkg::SCORE_W-1:0] leaky;

  assign scaled  = wh_i * attn_coef_i;
  assign shifted = scaled >>> attn_shift_i;
  // Negative side keeps a quarter of its slope.
  assign leaky   = shifted[gat_pkg::SCORE_W-1] ? (shifted >>> 2) : shifted;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_vld_o <= 1'b0;
    end else begin
      score_vld_o <= wh_vld_i;
    end
  end

  assign score_rdy_o = ~score_vld_o;

  always_ff @(posedge clk) begin
    if (wh_vld_i) begin
      score_o    <= leaky;
      wh_o       <= wh_i;
      grp_last_o <= grp_last_i;
    end
  end

endmodule

`default_nettype wire

/* hw/debugger.sv */
`timescale 1ns/1ps
`default_nettype none

module debugger (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               spmm_vld_i,
  input  logic                               spmm_rdy_i,
  input  logic                               dmvm_vld_i,
  input  logic                               dmvm_rdy_i,
  input  logic                               sm_vld_i,
  input  logic                               sm_rdy_i,
  input  logic                               aggr_vld_i,
  input  logic                               aggr_rdy_i,
  input  logic                               prod_vld_i,
  input  logic [gat_pkg::PROD_W-1:0]         prod_i,
  input  logic [gat_pkg::NODE_W-1:0]         node_idx_i,
  input  logic                               feat_bram_ena_i,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0]    feat_bram_addra_i,
  output logic [gat_pkg::DBG_W-1:0]          debug_1_o,
  output logic [gat_pkg::DBG_W-1:0]          debug_2_o,
  output logic [gat_pkg::DBG_W-1:0]          debug_3_o
);

  logic [7:0]                  seen_q;
  logic [7:0]                  level;
  logic                        wr_seen_q;
  logic                        high_seen_q;
  logic [gat_pkg::DBG_W-1:0]   sm_cnt_q;
  logic [gat_pkg::PROD_W-1:0]  cap_a_q;
  logic [gat_pkg::PROD_W-1:0]  cap_b_q;

  // Bit 7 down to bit 0 in pipeline order.
  assign level = {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i,
                  sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_q      <= '0;
      wr_seen_q   <= 1'b0;
      high_seen_q <= 1'b0;
      sm_cnt_q    <= '0;
      cap_a_q     <= '0;
      cap_b_q     <= '0;
    end else begin
      seen_q <= seen_q | level; // Flags never clear once set.
      if (sm_vld_i) begin
        sm_cnt_q <= sm_cnt_q + 1'b1;
      end
      if (feat_bram_ena_i) begin
        wr_seen_q <= 1'b1;
        if (feat_bram_addra_i >= gat_pkg::FEAT_HIGH_ADDR) begin
          high_seen_q <= 1'b1;
        end
      end
      // Keep the most recent product of each watched node.
      if (prod_vld_i && node_idx_i == gat_pkg::CAPTURE_NODE_A) begin
        cap_a_q <= prod_i;
      end
      if (prod_vld_i && node_idx_i == gat_pkg::CAPTURE_NODE_B) begin
        cap_b_q <= prod_i;
      end
    end
  end

  assign debug_1_o = sm_cnt_q;
  assign debug_2_o = {{(gat_pkg::DBG_W - 10){1'b0}}, high_seen_q, wr_seen_q, seen_q};
  assign debug_3_o = {cap_b_q, cap_a_q};

endmodule

`default_nettype wire

/* hw/gat_layer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_layer_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                nz_vld_i,
  input  logic signed [gat_pkg::VAL_W-1:0]    nz_val_i,
  input  logic        [gat_pkg::COL_W-1:0]    nz_col_i,
  input  logic                                nz_last_i,
  input  logic                                grp_last_i,
  input  logic                                wgt_we_i,
  input  logic        [gat_pkg::COL_W-1:0]    wgt_addr_i,
  input  logic signed [gat_pkg::WGT_W-1:0]    wgt_data_i,
  input  logic signed [gat_pkg::WGT_W-1:0]    attn_coef_i,
  input  logic        [gat_pkg::SHIFT_W-1:0]  attn_shift_i,
  input  logic        [gat_pkg::FEAT_ADDR_W-1:0] feat_base_i,
  output logic                                ready_o,
  output logic                                feat_bram_ena_o,
  output logic        [gat_pkg::FEAT_ADDR_W-1:0] feat_bram_addra_o,
  output logic        [gat_pkg::FEAT_W-1:0]   feat_bram_din_o,
  output logic        [gat_pkg::DBG_W-1:0]    debug_1_o,
  output logic        [gat_pkg::DBG_W-1:0]    debug_2_o,
  output logic        [gat_pkg::DBG_W-1:0]    debug_3_o
);

  logic                                  spmm_vld;
  logic                                  spmm_rdy;
  logic signed [gat_pkg::WH_W-1:0]       spmm_wh;
  logic                                  spmm_grp;
  logic        [gat_pkg::NODE_W-1:0]     node_idx;
  logic                                  prod_vld;
  logic signed [gat_pkg::PROD_W-1:0]     prod;
  logic                                  dmvm_vld;
  logic                                  dmvm_rdy;
  logic signed [gat_pkg::SCORE_W-1:0]    score;
  logic signed [gat_pkg::WH_W-1:0]       dmvm_wh;
  logic                                  dmvm_grp;
  logic                                  sm_vld;
  logic                                  sm_rdy;
  logic        [gat_pkg::ATTN_WGT_W-1:0] attn_wgt;
  logic signed [gat_pkg::WH_W-1:0]       sm_wh;
  logic                                  sm_grp;
  logic                                  aggr_vld;
  logic                                  aggr_rdy;

  spmm_engine u_spmm_engine (
    .clk, .rst_n,
    .nz_vld_i, .nz_val_i, .nz_col_i, .nz_last_i, .grp_last_i,
    .wgt_we_i, .wgt_addr_i, .wgt_data_i,
    .spmm_vld_o (spmm_vld), .spmm_rdy_o (spmm_rdy), .wh_o (spmm_wh),
    .grp_last_o (spmm_grp), .node_idx_o (node_idx),
    .prod_vld_o (prod_vld), .prod_o (prod)
  );

  attn_score_unit u_attn_score_unit (
    .clk, .rst_n,
    .wh_vld_i (spmm_vld), .wh_i (spmm_wh), .grp_last_i (spmm_grp),
    .attn_coef_i, .attn_shift_i,
    .score_vld_o (dmvm_vld), .score_rdy_o (dmvm_rdy), .score_o (score),
    .wh_o (dmvm_wh), .grp_last_o (dmvm_grp)
  );

  softmax_weight_unit u_softmax_weight_unit (
    .clk, .rst_n,
    .score_vld_i (dmvm_vld), .score_i (score), .wh_i (dmvm_wh), .grp_last_i (dmvm_grp),
    .wgt_vld_o (sm_vld), .wgt_rdy_o (sm_rdy), .attn_wgt_o (attn_wgt),
    .wh_o (sm_wh), .grp_last_o (sm_grp)
  );

  aggregator u_aggregator (
    .clk, .rst_n,
    .wgt_vld_i (sm_vld), .attn_wgt_i (attn_wgt), .wh_i (sm_wh), .grp_last_i (sm_grp),
    .feat_base_i,
    .aggr_vld_o (aggr_vld), .aggr_rdy_o (aggr_rdy),
    .feat_bram_ena_o, .feat_bram_addra_o, .feat_bram_din_o
  );

  debugger u_debugger (
    .clk, .rst_n,
    .spmm_vld_i (spmm_vld), .spmm_rdy_i (spmm_rdy),
    .dmvm_vld_i (dmvm_vld), .dmvm_rdy_i (dmvm_rdy),
    .sm_vld_i (sm_vld), .sm_rdy_i (sm_rdy),
    .aggr_vld_i (aggr_vld), .aggr_rdy_i (aggr_rdy),
    .prod_vld_i (prod_vld), .prod_i (prod), .node_idx_i (node_idx),
    .feat_bram_ena_i (feat_bram_ena_o), .feat_bram_addra_i (feat_bram_addra_o),
    .debug_1_o, .debug_2_o, .debug_3_o
  );

  assign ready_o = aggr_rdy & spmm_rdy; // Host may start a group only when both are idle.

endmodule

`default_nettype wire

/* hw/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // Input nonzero stream.
  localparam int VAL_W    = 8;
  localparam int COL_W    = 4;
  localparam int NUM_COLS = 16;

  // Projection datapath.
  localparam int WGT_W  = 8;
  localparam int PROD_W = 16;
  localparam int WH_W   = 24;
  localparam int NODE_W = 14;

  // Attention score and softmax weight.
  localparam int SCORE_W    = WH_W + WGT_W;
  localparam int SHIFT_W    = 4;
  localparam int ATTN_WGT_W = 1 << SHIFT_W; // Holds 2**15 unsigned.

  // Aggregation and division.
  localparam int DEN_W    = 20;
  localparam int ACC_W    = 44;
  localparam int FEAT_W   = 32;
  localparam int DIV_HI_W = ACC_W - FEAT_W; // Dividend bits preloaded into the remainder.

  localparam int FEAT_ADDR_W = 16;
  localparam logic [FEAT_ADDR_W-1:0] FEAT_HIGH_ADDR = 16'd43328;

  // Debug monitor.
  localparam int DBG_W = 32;
  localparam logic [NODE_W-1:0] CAPTURE_NODE_A = 14'd10;
  localparam logic [NODE_W-1:0] CAPTURE_NODE_B = 14'd20;

endpackage

`default_nettype wire

/* hw/softmax_weight_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module softmax_weight_unit (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  score_vld_i,
  input  logic signed [gat_pkg::SCORE_W-1:0]    score_i,
  input  logic signed [gat_pkg::WH_W-1:0]       wh_i,
  input  logic                                  grp_last_i,
  output logic                                  wgt_vld_o,
  output logic                                  wgt_rdy_o,
  output logic        [gat_pkg::ATTN_WGT_W-1:0] attn_wgt_o,
  output logic signed [gat_pkg::WH_W-1:0]       wh_o,
  output logic                                  grp_last_o
);

  logic [gat_pkg::SHIFT_W-1:0]    clamped;
  logic [gat_pkg::ATTN_WGT_W-1:0] pow2;

  // Saturate the score into the exponent range.
  always_comb begin
    if (score_i[gat_pkg::SCORE_W-1]) begin
      clamped = '0;
    end else if (score_i > (1 << gat_pkg::SHIFT_W) - 1) begin
      clamped = '1;
    end else begin
      clamped = score_i[gat_pkg::SHIFT_W-1:0];
    end
  end

  assign pow2 = {{(gat_pkg::ATTN_WGT_W - 1){1'b0}}, 1'b1} << clamped; // Stands in for exp.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wgt_vld_o <= 1'b0;
    end else begin
      wgt_vld_o <= score_vld_i;
    end
  end

  assign wgt_rdy_o = ~wgt_vld_o;

  always_ff @(posedge clk) begin
    if (score_vld_i) begin
      attn_wgt_o <= pow2;
      wh_o       <= wh_i;
      grp_last_o <= grp_last_i;
    end
  end

endmodule

`default_nettype wire

/* hw/spmm_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spmm_engine (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              nz_vld_i,
  input  logic signed [gat_pkg::VAL_W-1:0]  nz_val_i,
  input  logic        [gat_pkg::COL_W-1:0]  nz_col_i,
  input  logic                              nz_last_i,
  input  logic                              grp_last_i,
  input  logic                              wgt_we_i,
  input  logic        [gat_pkg::COL_W-1:0]  wgt_addr_i,
  input  logic signed [gat_pkg::WGT_W-1:0]  wgt_data_i,
  output logic                              spmm_vld_o,
  output logic                              spmm_rdy_o,
  output logic signed [gat_pkg::WH_W-1:0]   wh_o,
  output logic                              grp_last_o,
  output logic        [gat_pkg::NODE_W-1:0] node_idx_o,
  output logic                              prod_vld_o,
  output logic signed [gat_pkg::PROD_W-1:0] prod_o
);

  logic signed [gat_pkg::WGT_W-1:0] wgt_q [gat_pkg::NUM_COLS];
  logic signed [gat_pkg::WH_W-1:0]  sum_q;
  logic signed [gat_pkg::WH_W-1:0]  sum_next;

  // Host-written weight table.
  always_ff @(posedge clk) begin
    if (wgt_we_i) begin
      wgt_q[wgt_addr_i] <= wgt_data_i;
    end
  end

  assign prod_vld_o = nz_vld_i;
  assign prod_o     = nz_val_i * wgt_q[nz_col_i];

  assign sum_next = sum_q + {{(gat_pkg::WH_W - gat_pkg::PROD_W){prod_o[gat_pkg::PROD_W-1]}},
                             prod_o};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spmm_vld_o <= 1'b0;
      spmm_rdy_o <= 1'b1;
      sum_q      <= '0;
      node_idx_o <= '0;
    end else begin
      spmm_vld_o <= nz_vld_i & nz_last_i;
      if (nz_vld_i) begin
        if (nz_last_i) begin
          sum_q      <= '0; // Next node starts from zero.
          spmm_rdy_o <= 1'b1;
          node_idx_o <= node_idx_o + 1'b1;
        end else begin
          sum_q      <= sum_next;
          spmm_rdy_o <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (nz_vld_i && nz_last_i) begin
      wh_o       <= sum_next;
      grp_last_o <= grp_last_i;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f files.f --top-module gat_layer_tb -o gat_layer_sim
./obj_dir/gat_layer_sim | tee sim.log
if grep -q "Simulation passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

/* test/gat_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_layer_tb;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  // About 15 groups of at most 12 nonzeros and a 34 cycle divide stay well under 1000 cycles.
  localparam int MAX_CYCLES  = 5000;

  logic        clk;
  logic        rst_n;
  logic        nz_vld_i;
  logic [7:0]  nz_val_i;
  logic [3:0]  nz_col_i;
  logic        nz_last_i;
  logic        grp_last_i;
  logic        wgt_we_i;
  logic [3:0]  wgt_addr_i;
  logic [7:0]  wgt_data_i;
  logic [7:0]  attn_coef_i;
  logic [3:0]  attn_shift_i;
  logic [15:0] feat_base_i;
  logic        ready_o;
  logic        feat_bram_ena_o;
  logic [15:0] feat_bram_addra_o;
  logic [31:0] feat_bram_din_o;
  logic [31:0] debug_1_o;
  logic [31:0] debug_2_o;
  logic [31:0] debug_3_o;

  logic [31:0] lfsr_q;
  int          model_wgt [16];
  int          node_cnt;  // Nodes sent since reset, matches the DUT node index.
  int          grp_cnt;   // Features written since reset.
  logic [15:0] cap_a;
  logic [15:0] cap_b;
  int          cycles;

  gat_layer_top u_gat_layer_top (
    .clk, .rst_n,
    .nz_vld_i, .nz_val_i, .nz_col_i, .nz_last_i, .grp_last_i,
    .wgt_we_i, .wgt_addr_i, .wgt_data_i,
    .attn_coef_i, .attn_shift_i, .feat_base_i,
    .ready_o, .feat_bram_ena_o, .feat_bram_addra_o, .feat_bram_din_o,
    .debug_1_o, .debug_2_o, .debug_3_o
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
    $display("Simulation failed");
    $fatal(1);
  end

  // Taps at bits 32, 22, 2 and 1.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // Scaled score with a quarter slope below zero.
  function automatic int score_of(input int wh, input int coef, input int shift);
    int s;
    s = (wh * coef) >>> shift;
    if (s < 0) begin
      s = s >>> 2;
    end
    return s;
  endfunction

  function automatic int weight_of(input int score);
    int c;
    if (score < 0) begin
      c = 0;
    end else if (score > 15) begin
      c = 15;
    end else begin
      c = score;
    end
    return 1 << c;
  endfunction

  task automatic tick();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic compare_word(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    assert (exp === act) else begin
      $display("Fail %s: expected 'h%0h, actual 'h%0h", name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic write_weight(input int col, input int value);
    wgt_we_i   = 1'b1;
    wgt_addr_i = col[3:0];
    wgt_data_i = value[7:0];
    model_wgt[col] = value;
    tick();
    wgt_we_i = 1'b0;
  endtask

  task automatic send_nz(input int val, input int col, input bit last, input bit grp,
                         inout int wh);
    int prod;
    prod = val * model_wgt[col];
    wh += prod;
    if (node_cnt == 10) begin
      cap_a = prod[15:0];
    end
    if (node_cnt == 20) begin
      cap_b = prod[15:0];
    end
    nz_vld_i   = 1'b1;
    nz_val_i   = val[7:0];
    nz_col_i   = col[3:0];
    nz_last_i  = last;
    grp_last_i = grp;
    tick();
    nz_vld_i   = 1'b0;
    nz_last_i  = 1'b0;
    grp_last_i = 1'b0;
    if (last) begin
      node_cnt++;
    end else begin
      compare_word("node busy ready", 0, ready_o); // Mid-node the projection is busy.
    end
  endtask

  task automatic send_node(input int nz, input bit grp, output int wh);
    logic [31:0] r;
    int          val;
    int          col;
    int          j;
    wh = 0;
    for (j = 0; j < nz; j++) begin
      r   = rand_bits(8);
      val = $signed(r[7:0]);
      r   = rand_bits(4);
      col = r;
      send_nz(val, col, j == nz - 1, grp && (j == nz - 1), wh);
    end
  endtask

  task automatic wait_write(input string name, input logic [31:0] exp_data);
    int          low_cnt;
    logic [15:0] exp_addr;
    low_cnt  = 0;
    exp_addr = feat_base_i + grp_cnt[15:0];
    while (!feat_bram_ena_o) begin
      if (!ready_o) begin
        low_cnt++;
      end
      tick();
    end
    compare_word({name, " data"}, exp_data, feat_bram_din_o);
    compare_word({name, " addr"}, exp_addr, feat_bram_addra_o);
    compare_word({name, " busy seen"}, 1, low_cnt > 0);
    compare_word({name, " ready after write"}, 1, ready_o);
    grp_cnt++;
  endtask

  task automatic run_group(input string name, input int n_nodes);
    longint      acc;
    longint      den;
    longint      q;
    logic [31:0] r;
    int          coef;
    int          shift;
    int          wh;
    int          w;
    int          i;
    acc   = 0;
    den   = 0;
    r     = rand_bits(8);
    coef  = $signed(r[7:0]);
    r     = rand_bits(2);
    shift = 10 + r; // Keeps scores spread across negative, in range and clamped.
    compare_word({name, " idle"}, 1, ready_o);
    attn_coef_i  = coef[7:0];
    attn_shift_i = shift[3:0];
    for (i = 0; i < n_nodes; i++) begin
      r = rand_bits(2);
      send_node(1 + r, i == n_nodes - 1, wh);
      w   = weight_of(score_of(wh, coef, shift));
      acc += longint'(w) * wh;
      den += w;
    end
    q = acc / den; // Integer division truncates toward zero.
    wait_write(name, q[31:0]);
  endtask

  task automatic check_reset();
    compare_word("reset debug_1", 0, debug_1_o);
    compare_word("reset debug_2", 0, debug_2_o);
    compare_word("reset debug_3", 0, debug_3_o);
    compare_word("reset feat ena", 0, feat_bram_ena_o);
    compare_word("reset ready", 1, ready_o);
    rst_n = 1'b1;
    tick();
    // Only the ready levels are high when idle, which pins the flag order.
    compare_word("idle stage flags", 32'h55, debug_2_o);
  endtask

  task automatic check_single_node();
    int wh;
    int c;
    for (c = 0; c < 16; c++) begin
      write_weight(c, 3 * c - 20);
    end
    attn_coef_i  = 8'd1;
    attn_shift_i = 4'd0;
    wh = 0;
    send_nz(5, 3, 1'b0, 1'b0, wh);
    send_nz(-7, 12, 1'b0, 1'b0, wh);
    send_nz(9, 0, 1'b1, 1'b1, wh);
    wait_write("single node", wh); // One node divides back to its own Wh.
  endtask

  task automatic check_random_groups();
    logic [31:0] r;
    int          c;
    int          g;
    for (c = 0; c < 16; c++) begin
      r = rand_bits(4);
      write_weight(c, $signed(r[3:0]));
    end
    for (g = 0; g < 12; g++) begin
      r = rand_bits(1);
      run_group($sformatf("random group %0d", g), 2 + r);
    end
  endtask

  task automatic check_debug_flags();
    tick();
    tick();
    compare_word("debug sm count", node_cnt, debug_1_o);
    compare_word("debug stage flags", 8'hff, debug_2_o[7:0]);
    compare_word("debug write seen", 1, debug_2_o[8]);
  endtask

  task automatic check_captures();
    compare_word("debug captures", {cap_b, cap_a}, debug_3_o);
  endtask

  task automatic check_high_region();
    compare_word("high flag low base", 0, debug_2_o[9]);
    feat_base_i = gat_pkg::FEAT_HIGH_ADDR;
    run_group("high region group", 2);
    tick();
    tick();
    compare_word("high flag high base", 1, debug_2_o[9]);
  endtask

  initial begin
    lfsr_q       = 32'h8596_06f2;
    rst_n        = 1'b0;
    nz_vld_i     = 1'b0;
    nz_val_i     = '0;
    nz_col_i     = '0;
    nz_last_i    = 1'b0;
    grp_last_i   = 1'b0;
    wgt_we_i     = 1'b0;
    wgt_addr_i   = '0;
    wgt_data_i   = '0;
    attn_coef_i  = '0;
    attn_shift_i = '0;
    feat_base_i  = 16'h0100;
    node_cnt     = 0;
    grp_cnt      = 0;
    cap_a        = '0;
    cap_b        = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    check_reset();
    check_single_node();
    check_random_groups();
    check_debug_flags();
    check_captures();
    check_high_region();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
